// File: schedulerPkg.sv
/* Widths and entry, tag and pointer types of the wakeup scheduler.
   Every scheduler block and the testbench refer to these by scoped name. */

`default_nettype none

package schedulerPkg;

    // dispatch and wakeup bandwidth per cycle.
    localparam int DISPATCH_WIDTH = 2;
    localparam int WAKEUP_WIDTH = 2;

    localparam int SRC_OP_NUM = 2; // sources per instruction.

    // issue queue geometry.
    localparam int ISSUE_QUEUE_ENTRY_NUM = 16;
    localparam int ISSUE_QUEUE_INDEX_BIT_WIDTH = $clog2(ISSUE_QUEUE_ENTRY_NUM);

    localparam int PREG_NUM_BIT_WIDTH = 6;

    // pointer to one issue queue entry.
    typedef logic [ISSUE_QUEUE_INDEX_BIT_WIDTH-1:0] IssueQueueIndexPath;

    // one bit for each issue queue entry.
    typedef logic [ISSUE_QUEUE_ENTRY_NUM-1:0] IssueQueueOneHotPath;

    typedef logic [PREG_NUM_BIT_WIDTH-1:0] PRegNumPath;

    // a wakeup tag names the destination physical register directly.
    typedef PRegNumPath SchedulerRegTag;

endpackage

`default_nettype wire

// File: dispatchIf.sv
/* Dispatch bundle from the rename side into the issue queue blocks.
   The top level drives the signals; the CAM and the entry tracker read them through sink. */

`timescale 1ns/100ps
`default_nettype none

interface dispatchIf;

    // one strobe and one target entry per lane.
    logic dispatch [schedulerPkg::DISPATCH_WIDTH];
    schedulerPkg::IssueQueueIndexPath dispatchPtr [schedulerPkg::DISPATCH_WIDTH];

    // source operand tags and their ready state as seen at rename.
    schedulerPkg::PRegNumPath dispatchedSrcRegNum
        [schedulerPkg::DISPATCH_WIDTH][schedulerPkg::SRC_OP_NUM];
    logic dispatchedSrcReady [schedulerPkg::DISPATCH_WIDTH][schedulerPkg::SRC_OP_NUM];

    modport sink (
        input dispatch,
        input dispatchPtr,
        input dispatchedSrcRegNum,
        input dispatchedSrcReady
    );

endinterface

`default_nettype wire

// File: sourceCam.sv
/* Source operand CAM of the issue queue. Stores each source tag and its ready bit,
   and sets ready bits when a broadcast wakeup tag matches. */

`timescale 1ns/100ps
`default_nettype none

module sourceCam (
    input  logic clk,
    input  logic reset,
    dispatchIf.sink disp,
    input  logic wakeup [schedulerPkg::WAKEUP_WIDTH],
    input  schedulerPkg::SchedulerRegTag wakeupDstTag [schedulerPkg::WAKEUP_WIDTH],
    output schedulerPkg::IssueQueueOneHotPath srcReadyAll
);

    // stored tag and ready bit of every source of every entry.
    schedulerPkg::PRegNumPath srcTag
        [schedulerPkg::ISSUE_QUEUE_ENTRY_NUM][schedulerPkg::SRC_OP_NUM];
    logic srcReady [schedulerPkg::ISSUE_QUEUE_ENTRY_NUM][schedulerPkg::SRC_OP_NUM];

    // match results against this cycle's wakeup tags.
    logic storedMatch [schedulerPkg::ISSUE_QUEUE_ENTRY_NUM][schedulerPkg::SRC_OP_NUM];
    logic incomingMatch [schedulerPkg::DISPATCH_WIDTH][schedulerPkg::SRC_OP_NUM];

    // compare every stored tag with every broadcast tag.
    always_comb begin
        for (int e = 0; e < schedulerPkg::ISSUE_QUEUE_ENTRY_NUM; e++) begin
            for (int s = 0; s < schedulerPkg::SRC_OP_NUM; s++) begin
                storedMatch[e][s] = 1'b0;
                for (int w = 0; w < schedulerPkg::WAKEUP_WIDTH; w++) begin
                    if (wakeup[w] && (wakeupDstTag[w] == srcTag[e][s])) begin
                        storedMatch[e][s] = 1'b1;
                    end
                end
            end
        end
    end

    // the same comparison on the incoming tags, so a wakeup in the dispatch cycle is caught.
    always_comb begin
        for (int d = 0; d < schedulerPkg::DISPATCH_WIDTH; d++) begin
            for (int s = 0; s < schedulerPkg::SRC_OP_NUM; s++) begin
                incomingMatch[d][s] = 1'b0;
                for (int w = 0; w < schedulerPkg::WAKEUP_WIDTH; w++) begin
                    if (wakeup[w] && (wakeupDstTag[w] == disp.dispatchedSrcRegNum[d][s])) begin
                        incomingMatch[d][s] = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int d = 0; d < schedulerPkg::DISPATCH_WIDTH; d++) begin
            if (disp.dispatch[d]) begin
                for (int s = 0; s < schedulerPkg::SRC_OP_NUM; s++) begin
                    srcTag[disp.dispatchPtr[d]][s] <= disp.dispatchedSrcRegNum[d][s];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int e = 0; e < schedulerPkg::ISSUE_QUEUE_ENTRY_NUM; e++) begin
                for (int s = 0; s < schedulerPkg::SRC_OP_NUM; s++) begin
                    srcReady[e][s] <= 1'b0;
                end
            end
        end else begin
            for (int e = 0; e < schedulerPkg::ISSUE_QUEUE_ENTRY_NUM; e++) begin
                for (int s = 0; s < schedulerPkg::SRC_OP_NUM; s++) begin
                    if (storedMatch[e][s]) begin
                        srcReady[e][s] <= 1'b1; // wakeup only ever sets.
                    end
                end
            end
            // a new instruction replaces whatever the entry held before.
            for (int d = 0; d < schedulerPkg::DISPATCH_WIDTH; d++) begin
                if (disp.dispatch[d]) begin
                    for (int s = 0; s < schedulerPkg::SRC_OP_NUM; s++) begin
                        srcReady[disp.dispatchPtr[d]][s] <=
                            disp.dispatchedSrcReady[d][s] | incomingMatch[d][s];
                    end
                end
            end
        end
    end

    always_comb begin
        for (int e = 0; e < schedulerPkg::ISSUE_QUEUE_ENTRY_NUM; e++) begin
            srcReadyAll[e] = 1'b1;
            for (int s = 0; s < schedulerPkg::SRC_OP_NUM; s++) begin
                srcReadyAll[e] = srcReadyAll[e] & srcReady[e][s];
            end
        end
    end

    // two lanes writing one entry would leave a half-written instruction.
    for (genvar i = 0; i < schedulerPkg::DISPATCH_WIDTH; i++) begin : lanePairA
        for (genvar j = i + 1; j < schedulerPkg::DISPATCH_WIDTH; j++) begin : lanePairB
            distinctLanePtr: assert property (@(posedge clk) disable iff (reset)
                (disp.dispatch[i] && disp.dispatch[j]) |->
                    (disp.dispatchPtr[i] != disp.dispatchPtr[j]))
                else $error("dispatch lanes %0d and %0d target one entry", i, j);
        end
    end

endmodule

`default_nettype wire

// File: entryTracker.sv
/* Valid bit of each issue queue entry. A dispatch sets it and an issue grant
   clears it; dispatch wins when both hit the same entry. */

`timescale 1ns/100ps
`default_nettype none

module entryTracker (
    input  logic clk,
    input  logic reset,
    dispatchIf.sink disp,
    input  schedulerPkg::IssueQueueOneHotPath issueGrant,
    output schedulerPkg::IssueQueueOneHotPath entryValid
);

    schedulerPkg::IssueQueueOneHotPath dispatchMask; // entries written this cycle.
    schedulerPkg::IssueQueueOneHotPath nextValid;

    always_comb begin
        dispatchMask = '0;
        for (int d = 0; d < schedulerPkg::DISPATCH_WIDTH; d++) begin
            if (disp.dispatch[d]) begin
                dispatchMask[disp.dispatchPtr[d]] = 1'b1;
            end
        end
    end

    // the grant frees first, so a dispatch into a granted entry keeps it valid.
    assign nextValid = (entryValid & ~issueGrant) | dispatchMask;

    always_ff @(posedge clk) begin
        if (reset) begin
            entryValid <= '0;
        end else begin
            entryValid <= nextValid;
        end
    end

    // the caller may reuse an entry only once it is free or is leaving this cycle.
    for (genvar d = 0; d < schedulerPkg::DISPATCH_WIDTH; d++) begin : laneCheck
        dispatchToFree: assert property (@(posedge clk) disable iff (reset)
            disp.dispatch[d] |->
                (!entryValid[disp.dispatchPtr[d]] || issueGrant[disp.dispatchPtr[d]]))
            else $error("lane %0d dispatched into busy entry %0d", d, disp.dispatchPtr[d]);
    end

endmodule

`default_nettype wire

// File: issueSelect.sv
/* Issue selection. Forms the operand-ready vector and grants the lowest ready entry
   in the same cycle unless issue is stalled. */

`timescale 1ns/100ps
`default_nettype none

module issueSelect (
    input  logic clk,
    input  schedulerPkg::IssueQueueOneHotPath entryValid,
    input  schedulerPkg::IssueQueueOneHotPath srcReadyAll,
    input  logic issueStall,
    output schedulerPkg::IssueQueueOneHotPath opReady,
    output logic issueValid,
    output schedulerPkg::IssueQueueIndexPath issuePtr,
    output schedulerPkg::IssueQueueOneHotPath issueGrant
);

    logic anyReady;

    // a stale ready bit in a free entry must never reach the picker.
    assign opReady = entryValid & srcReadyAll;
    assign anyReady = |opReady;

    // scan downward so the lowest set index is the last one written.
    always_comb begin
        issuePtr = '0;
        for (int i = schedulerPkg::ISSUE_QUEUE_ENTRY_NUM - 1; i >= 0; i--) begin
            if (opReady[i]) begin
                issuePtr = schedulerPkg::IssueQueueIndexPath'(i);
            end
        end
    end

    assign issueValid = anyReady && !issueStall; // back-pressure holds everything.

    always_comb begin
        issueGrant = '0;
        if (issueValid) begin
            issueGrant[issuePtr] = 1'b1;
        end
    end

    // only one entry is freed per cycle.
    singleGrant: assert property (@(posedge clk) $onehot0(issueGrant))
        else $error("issue grant %h has more than one bit set", issueGrant);

endmodule

`default_nettype wire

// File: wakeupScheduler.sv
/* Top level of the issue queue wakeup logic. Takes packed dispatch and wakeup ports,
   and ties the source CAM, entry tracker and issue selector together. */

`timescale 1ns/100ps
`default_nettype none

module wakeupScheduler (
    input  logic clk,
    input  logic reset,
    input  logic [schedulerPkg::DISPATCH_WIDTH-1:0] dispatch,
    input  schedulerPkg::IssueQueueIndexPath [schedulerPkg::DISPATCH_WIDTH-1:0] dispatchPtr,
    input  schedulerPkg::PRegNumPath
        [schedulerPkg::DISPATCH_WIDTH-1:0][schedulerPkg::SRC_OP_NUM-1:0] dispatchedSrcRegNum,
    input  logic
        [schedulerPkg::DISPATCH_WIDTH-1:0][schedulerPkg::SRC_OP_NUM-1:0] dispatchedSrcReady,
    input  logic [schedulerPkg::WAKEUP_WIDTH-1:0] wakeup,
    input  schedulerPkg::SchedulerRegTag [schedulerPkg::WAKEUP_WIDTH-1:0] wakeupDstTag,
    input  logic issueStall,
    output schedulerPkg::IssueQueueOneHotPath opReady,
    output logic issueValid,
    output schedulerPkg::IssueQueueIndexPath issuePtr
);

    dispatchIf disp ();

    logic unpackedWakeup [schedulerPkg::WAKEUP_WIDTH];
    schedulerPkg::SchedulerRegTag unpackedWakeupDstTag [schedulerPkg::WAKEUP_WIDTH];

    schedulerPkg::IssueQueueOneHotPath srcReadyAll;
    schedulerPkg::IssueQueueOneHotPath entryValid;
    schedulerPkg::IssueQueueOneHotPath issueGrant;

    // packed ports into the unpacked bundle the inner blocks expect.
    always_comb begin
        for (int d = 0; d < schedulerPkg::DISPATCH_WIDTH; d++) begin
            disp.dispatch[d] = dispatch[d];
            disp.dispatchPtr[d] = dispatchPtr[d];
            for (int s = 0; s < schedulerPkg::SRC_OP_NUM; s++) begin
                disp.dispatchedSrcRegNum[d][s] = dispatchedSrcRegNum[d][s];
                disp.dispatchedSrcReady[d][s] = dispatchedSrcReady[d][s];
            end
        end
        for (int w = 0; w < schedulerPkg::WAKEUP_WIDTH; w++) begin
            unpackedWakeup[w] = wakeup[w];
            unpackedWakeupDstTag[w] = wakeupDstTag[w];
        end
    end

    sourceCam i_sourceCam (
        .clk          (clk),
        .reset        (reset),
        .disp         (disp.sink),
        .wakeup       (unpackedWakeup),
        .wakeupDstTag (unpackedWakeupDstTag),
        .srcReadyAll  (srcReadyAll)
    );

    entryTracker i_entryTracker (
        .clk        (clk),
        .reset      (reset),
        .disp       (disp.sink),
        .issueGrant (issueGrant),
        .entryValid (entryValid)
    );

    issueSelect i_issueSelect (
        .clk         (clk),
        .entryValid  (entryValid),
        .srcReadyAll (srcReadyAll),
        .issueStall  (issueStall),
        .opReady     (opReady),
        .issueValid  (issueValid),
        .issuePtr    (issuePtr),
        .issueGrant  (issueGrant)
    );

endmodule

`default_nettype wire

// File: tbScheduler.sv
/* Random-stimulus testbench for the wakeup scheduler. A model of every entry predicts
   opReady and the issue grant, which are checked after each rising clock edge. */

`timescale 1ns/100ps
`default_nettype none

module tbScheduler;

    logic clk;
    logic reset;
    logic [schedulerPkg::DISPATCH_WIDTH-1:0] dispatch;
    schedulerPkg::IssueQueueIndexPath [schedulerPkg::DISPATCH_WIDTH-1:0] dispatchPtr;
    schedulerPkg::PRegNumPath
        [schedulerPkg::DISPATCH_WIDTH-1:0][schedulerPkg::SRC_OP_NUM-1:0] dispatchedSrcRegNum;
    logic [schedulerPkg::DISPATCH_WIDTH-1:0][schedulerPkg::SRC_OP_NUM-1:0] dispatchedSrcReady;
    logic [schedulerPkg::WAKEUP_WIDTH-1:0] wakeup;
    schedulerPkg::SchedulerRegTag [schedulerPkg::WAKEUP_WIDTH-1:0] wakeupDstTag;
    logic issueStall;
    schedulerPkg::IssueQueueOneHotPath opReady;
    logic issueValid;
    schedulerPkg::IssueQueueIndexPath issuePtr;

    // reference copy of the entries.
    logic modelValid [schedulerPkg::ISSUE_QUEUE_ENTRY_NUM];
    schedulerPkg::PRegNumPath modelTag
        [schedulerPkg::ISSUE_QUEUE_ENTRY_NUM][schedulerPkg::SRC_OP_NUM];
    logic modelReady [schedulerPkg::ISSUE_QUEUE_ENTRY_NUM][schedulerPkg::SRC_OP_NUM];

    integer seed;
    int stimCycles = 2000;
    int cycleCount = 0;
    int errors = 0;
    int checks = 0;
    bit sawFull = 1'b0;
    bit sawEmpty = 1'b0; // set only once the queue has been full.

    wakeupScheduler i_wakeupScheduler (
        .clk                 (clk),
        .reset               (reset),
        .dispatch            (dispatch),
        .dispatchPtr         (dispatchPtr),
        .dispatchedSrcRegNum (dispatchedSrcRegNum),
        .dispatchedSrcReady  (dispatchedSrcReady),
        .wakeup              (wakeup),
        .wakeupDstTag        (wakeupDstTag),
        .issueStall          (issueStall),
        .opReady             (opReady),
        .issueValid          (issueValid),
        .issuePtr            (issuePtr)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= stimCycles + 100) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleCount);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic bit randPct(input int pct);
        int r;
        r = int'({$random(seed)} % 100);
        return r < pct;
    endfunction

    function automatic int randBelow(input int n);
        return int'({$random(seed)} % n);
    endfunction

    // only eight tags, so that wakeups hit waiting sources often.
    function automatic schedulerPkg::PRegNumPath randTag();
        int r;
        r = $random(seed);
        return {3'b000, r[2:0]};
    endfunction

    function automatic schedulerPkg::IssueQueueOneHotPath expectedOpReady();
        schedulerPkg::IssueQueueOneHotPath op;
        op = '0;
        for (int e = 0; e < schedulerPkg::ISSUE_QUEUE_ENTRY_NUM; e++) begin
            op[e] = modelValid[e] & modelReady[e][0] & modelReady[e][1];
        end
        return op;
    endfunction

    function automatic int lowestIndex(input schedulerPkg::IssueQueueOneHotPath op);
        int idx;
        idx = -1;
        for (int e = 0; e < schedulerPkg::ISSUE_QUEUE_ENTRY_NUM; e++) begin
            if (op[e] && idx < 0) begin
                idx = e;
            end
        end
        return idx;
    endfunction

    function automatic bit tagWoken(input schedulerPkg::PRegNumPath tag);
        bit hit;
        hit = 1'b0;
        for (int w = 0; w < schedulerPkg::WAKEUP_WIDTH; w++) begin
            if (wakeup[w] && wakeupDstTag[w] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic driveIdle();
        dispatch = '0;
        dispatchPtr = '0;
        dispatchedSrcRegNum = '0;
        dispatchedSrcReady = '0;
        wakeup = '0;
        wakeupDstTag = '0;
        issueStall = 1'b0;
    endtask

    task automatic driveStimulus(input bit fillPhase);
        int freeList[$];
        int pick;
        int grantIdx;
        int dispPct;
        int wakePct;
        dispPct = fillPhase ? 75 : 5;
        wakePct = fillPhase ? 40 : 75;
        issueStall = randPct(fillPhase ? 25 : 5);
        grantIdx = issueStall ? -1 : lowestIndex(expectedOpReady());
        // an entry granted this cycle may be refilled in the same cycle.
        for (int e = 0; e < schedulerPkg::ISSUE_QUEUE_ENTRY_NUM; e++) begin
            if (!modelValid[e] || e == grantIdx) begin
                freeList.push_back(e);
            end
        end
        for (int d = 0; d < schedulerPkg::DISPATCH_WIDTH; d++) begin
            dispatch[d] = 1'b0;
            dispatchPtr[d] = '0;
            if (freeList.size() > 0 && randPct(dispPct)) begin
                pick = randBelow(freeList.size());
                dispatch[d] = 1'b1;
                dispatchPtr[d] = schedulerPkg::IssueQueueIndexPath'(freeList[pick]);
                freeList.delete(pick); // no two lanes on one entry.
            end
            for (int s = 0; s < schedulerPkg::SRC_OP_NUM; s++) begin
                dispatchedSrcRegNum[d][s] = randTag();
                dispatchedSrcReady[d][s] = randPct(50);
            end
        end
        for (int w = 0; w < schedulerPkg::WAKEUP_WIDTH; w++) begin
            wakeup[w] = randPct(wakePct);
            wakeupDstTag[w] = randTag();
        end
    endtask

    // next state at the rising edge, wakeup first, then grant, then dispatch.
    task automatic updateModel();
        int grantIdx;
        int ptr;
        grantIdx = issueStall ? -1 : lowestIndex(expectedOpReady());
        for (int e = 0; e < schedulerPkg::ISSUE_QUEUE_ENTRY_NUM; e++) begin
            for (int s = 0; s < schedulerPkg::SRC_OP_NUM; s++) begin
                if (tagWoken(modelTag[e][s])) begin
                    modelReady[e][s] = 1'b1;
                end
            end
        end
        if (grantIdx >= 0) begin
            modelValid[grantIdx] = 1'b0;
        end
        for (int d = 0; d < schedulerPkg::DISPATCH_WIDTH; d++) begin
            if (dispatch[d]) begin
                ptr = int'(dispatchPtr[d]);
                modelValid[ptr] = 1'b1;
                for (int s = 0; s < schedulerPkg::SRC_OP_NUM; s++) begin
                    modelTag[ptr][s] = dispatchedSrcRegNum[d][s];
                    modelReady[ptr][s] = dispatchedSrcReady[d][s]
                        | tagWoken(dispatchedSrcRegNum[d][s]);
                end
            end
        end
    endtask

    task automatic checkOutputs();
        schedulerPkg::IssueQueueOneHotPath expOp;
        bit expValid;
        int expPtr;
        expOp = expectedOpReady();
        expValid = (expOp != '0) && !issueStall;
        expPtr = lowestIndex(expOp);
        checks++;
        assert (opReady === expOp) else begin
            errors++;
            $display("Fail %0t: opReady %h, expected %h", $time, opReady, expOp);
        end
        assert (issueValid === expValid) else begin
            errors++;
            $display("Fail %0t: issueValid %b, expected %b", $time, issueValid, expValid);
        end
        if (expValid) begin
            assert (int'(issuePtr) == expPtr) else begin
                errors++;
                $display("Fail %0t: issuePtr %0d, expected %0d", $time, issuePtr, expPtr);
            end
        end
    endtask

    task automatic trackOccupancy();
        int count;
        count = 0;
        for (int e = 0; e < schedulerPkg::ISSUE_QUEUE_ENTRY_NUM; e++) begin
            count += int'(modelValid[e]);
        end
        if (count == schedulerPkg::ISSUE_QUEUE_ENTRY_NUM) begin
            sawFull = 1'b1;
        end
        if (sawFull && count == 0) begin
            sawEmpty = 1'b1;
        end
    endtask

    initial begin
        seed = 32'h75ea_c7f5;
        clk = 1'b0;
        reset = 1'b1;
        driveIdle();
        for (int e = 0; e < schedulerPkg::ISSUE_QUEUE_ENTRY_NUM; e++) begin
            modelValid[e] = 1'b0;
            for (int s = 0; s < schedulerPkg::SRC_OP_NUM; s++) begin
                modelTag[e][s] = '0;
                modelReady[e][s] = 1'b0;
            end
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #5;
        checkOutputs(); // empty queue straight out of reset.

        // windows of 250 cycles, filling for 100 and draining for the rest.
        for (int c = 0; c < stimCycles; c++) begin
            @(negedge clk);
            driveStimulus((c % 250) < 100);
            @(posedge clk);
            updateModel();
            #5;
            checkOutputs();
            trackOccupancy();
        end
        @(negedge clk);
        driveIdle();

        assert (sawFull && sawEmpty) else begin
            errors++;
            $display("The queue was never filled and then drained again during the run");
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
schedulerPkg.sv
dispatchIf.sv
sourceCam.sv
entryTracker.sv
issueSelect.sv
wakeupScheduler.sv
tbScheduler.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbScheduler
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
